// ==== Makefile ====
# Verilator build and run of the memory unit testbench

VERILATOR ?= verilator
TOP       ?= tb_memory_unit
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Failure reported, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "No verdict in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
    import mem_pkg::*;
#(
    parameter int LINE_DEPTH = 375,
    localparam int ADDR_WIDTH = $clog2(LINE_DEPTH)
) (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic [INSTR_WIDTH-1:0]  instr_in,
    input  logic                    instr_valid_in,
    output logic [ADDR_WIDTH-1:0]   addr,          // Line address register
    output logic                    wr_en,         // One-cycle write request
    output line_src_e               write_src,     // Line to be written
    output logic                    rd_en,         // One-cycle read request
    output logic                    rd_use_new_c,  // Flag carried with the read
    output logic                    rd_fma_valid,  // Flag carried with the read
    output logic                    word_load,     // One-cycle LOADI request
    output logic [REG_WIDTH-1:0]    word_index,
    output logic [WORD_WIDTH-1:0]   word_data
);

    // ------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------
    opcode_e                 opcode;
    logic [REG_WIDTH-1:0]    reg_a;
    logic [REG_WIDTH-1:0]    reg_b;
    logic [WORD_WIDTH-1:0]   imm;

    assign opcode = opcode_e'(instr_in[OPCODE_HI:OPCODE_LO]);
    assign reg_a  = instr_in[REG_A_HI:REG_A_LO];  // Word index or replace-c
    assign reg_b  = instr_in[REG_B_HI:REG_B_LO];  // The fma-valid field
    assign imm    = instr_in[IMM_HI:IMM_LO];

    // Decoded strobes for the current instruction
    logic is_sma;
    logic is_loadi;
    logic is_sendl;
    logic is_loadb;
    logic is_writeb;

    always_comb begin
        is_sma    = 1'b0;
        is_loadi  = 1'b0;
        is_sendl  = 1'b0;
        is_loadb  = 1'b0;
        is_writeb = 1'b0;
        if (instr_valid_in) begin
            case (opcode)
                OP_SMA:    is_sma    = 1'b1;
                OP_LOADI:  is_loadi  = 1'b1;
                OP_SENDL:  is_sendl  = 1'b1;
                OP_LOADB:  is_loadb  = 1'b1;
                OP_WRITEB: is_writeb = 1'b1;
                // NOP and the core opcodes leave the memory alone
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Request registers
    // ------------------------------------------------------------
    // Every request lives for exactly the cycle after its sample edge
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            addr      <= '0;
            wr_en     <= 1'b0;
            rd_en     <= 1'b0;
            word_load <= 1'b0;
            write_src <= SRC_STAGING;
        end else begin
            wr_en     <= is_sendl | is_loadb;
            rd_en     <= is_writeb;
            word_load <= is_loadi;

            // SMA, LOADB and WRITEB all leave their immediate as the address
            if (is_sma || is_loadb || is_writeb) begin
                addr <= imm[ADDR_WIDTH-1:0];
            end

            if (is_sendl) begin
                write_src <= SRC_STAGING;  // SENDL writes to the address already held
            end else if (is_loadb) begin
                write_src <= SRC_BUFFER;
            end
        end
    end

    // Payload fields only matter while their strobe is high
    always_ff @(posedge clk_in) begin
        word_index   <= reg_a;
        word_data    <= imm;
        rd_use_new_c <= (reg_a == REG_WIDTH'(1));  // Only the value one counts as set
        rd_fma_valid <= (reg_b == REG_WIDTH'(1));
    end

endmodule

// ==== hw/line_assembler.sv ====
`timescale 1ns/1ps

module line_assembler
    import mem_pkg::*;
#(
    parameter int FMA_COUNT = 2,
    localparam int WORDS_PER_LINE = WORDS_PER_FMA * FMA_COUNT,
    localparam int LINE_WIDTH = WORDS_PER_LINE * WORD_WIDTH
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   word_load,
    input  logic [REG_WIDTH-1:0]   word_index,
    input  logic [WORD_WIDTH-1:0]  word_data,
    input  line_src_e              write_src,
    input  logic [LINE_WIDTH-1:0]  write_buffer_read_in,
    input  logic                   write_buffer_valid_in,
    output logic [LINE_WIDTH-1:0]  write_line    // Data for the next RAM write
);

    // ------------------------------------------------------------
    // Staging line
    // ------------------------------------------------------------
    logic [LINE_WIDTH-1:0] staging_line;

    // Word 0 sits in the top bits so a line reads a0 b0 c0 a1 b1 c1 from the MSB down
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            staging_line <= '0;
        end else if (word_load) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                if (word_index == REG_WIDTH'(w)) begin
                    staging_line[(WORDS_PER_LINE - 1 - w) * WORD_WIDTH +: WORD_WIDTH] <= word_data;
                end
            end
            // An index past the last word matches nothing and is dropped
        end
    end

    // ------------------------------------------------------------
    // Write buffer capture
    // ------------------------------------------------------------
    // The capture goes through one holding stage so that LOADB sampled at
    // edge N writes the line captured before N, even if a new line arrives on N
    logic [LINE_WIDTH-1:0] incoming_line;
    logic                  incoming_valid;
    logic [LINE_WIDTH-1:0] captured_line;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            incoming_valid <= 1'b0;
        end else begin
            incoming_valid <= write_buffer_valid_in;
        end
    end

    always_ff @(posedge clk_in) begin
        if (write_buffer_valid_in) begin
            incoming_line <= write_buffer_read_in;  // Latest line from the buffer
        end
        if (incoming_valid) begin
            captured_line <= incoming_line;  // Visible to LOADB one edge later
        end
    end

    // Write data is picked from whichever line the decoder asked for
    assign write_line = (write_src == SRC_BUFFER) ? captured_line : staging_line;

endmodule

// ==== hw/line_ram.sv ====
`timescale 1ns/1ps

module line_ram
    import mem_pkg::*;
#(
    parameter int FMA_COUNT = 2,
    parameter int LINE_DEPTH = 375,
    localparam int LINE_WIDTH = WORDS_PER_FMA * FMA_COUNT * WORD_WIDTH,
    localparam int ADDR_WIDTH = $clog2(LINE_DEPTH)
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic [ADDR_WIDTH-1:0]  addr,
    input  logic                   wr_en,
    input  logic [LINE_WIDTH-1:0]  write_line,
    input  logic                   rd_en,
    input  logic                   rd_use_new_c,
    input  logic                   rd_fma_valid,
    output logic [LINE_WIDTH-1:0]  abc_out,
    output logic                   abc_valid_out,
    output logic                   use_new_c_out,
    output logic                   fma_output_can_be_valid_out
);

    // ------------------------------------------------------------
    // Array with registered read
    // ------------------------------------------------------------
    logic [LINE_WIDTH-1:0] mem [LINE_DEPTH];
    logic [LINE_WIDTH-1:0] rd_data;     // First read stage
    logic                  addr_in_range;

    // Addresses past the last line neither write nor return stored data
    assign addr_in_range = int'(addr) < LINE_DEPTH;

    // Single port in read-first style like the block RAM it models
    always_ff @(posedge clk_in) begin
        if (wr_en && addr_in_range) begin
            mem[addr] <= write_line;
        end
        if (rd_en) begin
            rd_data <= addr_in_range ? mem[addr] : '0;
        end
    end

    // ------------------------------------------------------------
    // Flag pipeline and output register
    // ------------------------------------------------------------
    logic rd_valid_q;  // Stage one marks a read sitting in rd_data
    logic use_new_c_q;
    logic fma_valid_q;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_en;
        end
    end

    // Flags ride beside the data so they leave together
    always_ff @(posedge clk_in) begin
        if (rd_en) begin
            use_new_c_q <= rd_use_new_c;
            fma_valid_q <= rd_fma_valid;
        end
    end

    // Stage two loads the outputs and pulses valid once per read
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            abc_out                     <= '0;
            abc_valid_out               <= 1'b0;
            use_new_c_out               <= 1'b0;
            fma_output_can_be_valid_out <= 1'b0;
        end else begin
            abc_valid_out <= rd_valid_q;
            if (rd_valid_q) begin
                abc_out                     <= rd_data;
                use_new_c_out               <= use_new_c_q;  // Held until the next read
                fma_output_can_be_valid_out <= fma_valid_q;
            end
        end
    end

endmodule

// ==== hw/mem_pkg.sv ====
package mem_pkg;

    // ------------------------------------------------------------
    // Instruction format
    // ------------------------------------------------------------
    // | opcode 4 | reg_a 4 | immediate 16 | reg_b 4 | reg_c 4 |
    localparam int INSTR_WIDTH = 32;  // Fixed by the instruction format
    localparam int WORD_WIDTH  = 16;  // One word is exactly one immediate
    localparam int REG_WIDTH   = 4;   // Width of each register field

    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 28;
    localparam int REG_A_HI  = 27;  // Word index for LOADI and replace-c for WRITEB
    localparam int REG_A_LO  = 24;
    localparam int IMM_HI    = 23;  // Line address or word value
    localparam int IMM_LO    = 8;
    localparam int REG_B_HI  = 7;   // The fma-valid field of WRITEB
    localparam int REG_B_LO  = 4;
    localparam int REG_C_HI  = 3;   // Not used by the memory
    localparam int REG_C_LO  = 0;

    localparam int WORDS_PER_FMA = 3;  // Each FMA takes an a, b and c word

    // ------------------------------------------------------------
    // Opcodes and write sources
    // ------------------------------------------------------------
    // The whole ISA is listed so that core opcodes decode cleanly as no-ops
    typedef enum logic [3:0] {
        OP_NOP    = 4'b0000,
        OP_END    = 4'b0001,  // Core only
        OP_XOR    = 4'b0010,  // Core only
        OP_ADDI   = 4'b0011,  // Core only
        OP_BGE    = 4'b0100,  // Core only
        OP_JUMP   = 4'b0101,  // Core only
        OP_SMA    = 4'b0110,  // Set the line address
        OP_LOADI  = 4'b0111,  // Put an immediate into one staging word
        OP_SENDL  = 4'b1000,  // Write the staging line to the line address
        OP_LOADB  = 4'b1001,  // Write the captured buffer line to the immediate address
        OP_WRITEB = 4'b1010   // Read the immediate address out to the FMAs
    } opcode_e;

    // Chooses which line goes into the RAM on a write
    typedef enum logic {
        SRC_STAGING = 1'b0,
        SRC_BUFFER  = 1'b1
    } line_src_e;

endpackage

// ==== hw/memory_unit.sv ====
`timescale 1ns/1ps

module memory_unit
    import mem_pkg::*;
#(
    parameter int FMA_COUNT = 2,     // Anything from 1 to 5 fits the word index field
    parameter int LINE_DEPTH = 375,  // Lines held in the RAM
    localparam int LINE_WIDTH = WORDS_PER_FMA * FMA_COUNT * WORD_WIDTH,
    localparam int ADDR_WIDTH = $clog2(LINE_DEPTH)
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic [INSTR_WIDTH-1:0] instr_in,
    input  logic                   instr_valid_in,   // One instruction per edge when high
    input  logic [LINE_WIDTH-1:0]  write_buffer_read_in,
    input  logic                   write_buffer_valid_in,
    output logic [LINE_WIDTH-1:0]  abc_out,          // a b c per FMA with FMA 0 on top
    output logic                   abc_valid_out,    // Pulses 2 cycles after each WRITEB
    output logic                   use_new_c_out,
    output logic                   fma_output_can_be_valid_out
);

    // ------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------
    logic [ADDR_WIDTH-1:0]  addr;
    logic                   wr_en;
    line_src_e              write_src;
    logic                   rd_en;
    logic                   rd_use_new_c;
    logic                   rd_fma_valid;
    logic                   word_load;
    logic [REG_WIDTH-1:0]   word_index;
    logic [WORD_WIDTH-1:0]  word_data;
    logic [LINE_WIDTH-1:0]  write_line;

    // Turns the instruction stream into one-cycle requests
    instr_decoder #(
        .LINE_DEPTH (LINE_DEPTH)
    ) u_instr_decoder (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .instr_in       (instr_in),
        .instr_valid_in (instr_valid_in),
        .addr           (addr),
        .wr_en          (wr_en),
        .write_src      (write_src),
        .rd_en          (rd_en),
        .rd_use_new_c   (rd_use_new_c),
        .rd_fma_valid   (rd_fma_valid),
        .word_load      (word_load),
        .word_index     (word_index),
        .word_data      (word_data)
    );

    // Builds lines from LOADI words or from the write buffer
    line_assembler #(
        .FMA_COUNT (FMA_COUNT)
    ) u_line_assembler (
        .clk_in                (clk_in),
        .rst_in                (rst_in),
        .word_load             (word_load),
        .word_index            (word_index),
        .word_data             (word_data),
        .write_src             (write_src),
        .write_buffer_read_in  (write_buffer_read_in),
        .write_buffer_valid_in (write_buffer_valid_in),
        .write_line            (write_line)
    );

    // Stores lines and drives the FMA side
    line_ram #(
        .FMA_COUNT  (FMA_COUNT),
        .LINE_DEPTH (LINE_DEPTH)
    ) u_line_ram (
        .clk_in                      (clk_in),
        .rst_in                      (rst_in),
        .addr                        (addr),
        .wr_en                       (wr_en),
        .write_line                  (write_line),
        .rd_en                       (rd_en),
        .rd_use_new_c                (rd_use_new_c),
        .rd_fma_valid                (rd_fma_valid),
        .abc_out                     (abc_out),
        .abc_valid_out               (abc_valid_out),
        .use_new_c_out               (use_new_c_out),
        .fma_output_can_be_valid_out (fma_output_can_be_valid_out)
    );

endmodule

// ==== tb.f ====
hw/mem_pkg.sv
hw/instr_decoder.sv
hw/line_assembler.sv
hw/line_ram.sv
hw/memory_unit.sv
testbench/memory_checker.sv
testbench/tb_memory_unit.sv

// ==== testbench/memory_checker.sv ====
`timescale 1ns/1ps

module memory_checker
    import mem_pkg::*;
#(
    parameter int FMA_COUNT = 2,
    parameter int LINE_DEPTH = 375,
    localparam int WORDS = WORDS_PER_FMA * FMA_COUNT,
    localparam int LINE_WIDTH = WORDS * WORD_WIDTH,
    localparam int ADDR_WIDTH = $clog2(LINE_DEPTH)
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic [INSTR_WIDTH-1:0] instr_in,
    input  logic                   instr_valid_in,
    input  logic [LINE_WIDTH-1:0]  write_buffer_read_in,
    input  logic                   write_buffer_valid_in,
    input  logic [LINE_WIDTH-1:0]  abc_out,
    input  logic                   abc_valid_out,
    input  logic                   use_new_c_out,
    input  logic                   fma_output_can_be_valid_out,
    output int                     error_count,
    output int                     pulse_count,  // Pulses matched against a WRITEB
    output int                     pending       // WRITEBs still waiting for their pulse
);

    // ------------------------------------------------------------
    // Reference model state
    // ------------------------------------------------------------
    logic [LINE_WIDTH-1:0] ref_mem [LINE_DEPTH];
    logic [ADDR_WIDTH-1:0] ref_addr;
    logic [LINE_WIDTH-1:0] ref_staging;
    logic [LINE_WIDTH-1:0] ref_captured;  // Last line taken from the write buffer
    logic [LINE_WIDTH+1:0] expect_q [$];  // {fma_valid, use_new_c, line} per WRITEB
    int                    due_q [$];     // Edge on which each pulse becomes visible
    int                    cycle;
    bit                    seen_pulse;    // Outputs must hold their reset value until set
    logic [1:0]            held_flags;    // {fma_valid, use_new_c} left by the last pulse

    // A WRITEB returns the stored line, and each flag is set only for a field of one
    function automatic logic [LINE_WIDTH+1:0] expected_read(
        input logic [ADDR_WIDTH-1:0] a,
        input logic [3:0]            replace_c,
        input logic [3:0]            fma_valid
    );
        logic [LINE_WIDTH-1:0] line;
        line = (int'(a) < LINE_DEPTH) ? ref_mem[a] : '0;  // Lines past the end read as zero
        return {fma_valid == 4'd1, replace_c == 4'd1, line};
    endfunction

    task automatic compare_value(input string name, input logic [LINE_WIDTH-1:0] expected,
                                 input logic [LINE_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------
    // Compare outputs, then advance the model
    // ------------------------------------------------------------
    always @(posedge clk_in) begin
        opcode_e               op;
        logic [3:0]            ra;
        logic [3:0]            rb;
        logic [WORD_WIDTH-1:0] imm;
        logic [LINE_WIDTH+1:0] exp_read;
        int                    due;
        int                    idx;

        cycle++;
        op  = opcode_e'(instr_in[OPCODE_HI:OPCODE_LO]);
        ra  = instr_in[REG_A_HI:REG_A_LO];  // Word index or replace-c
        rb  = instr_in[REG_B_HI:REG_B_LO];  // The fma-valid field
        imm = instr_in[IMM_HI:IMM_LO];
        idx = int'(ra);

        if (rst_in) begin
            ref_addr    = '0;
            ref_staging = '0;
            seen_pulse  = 1'b0;
            held_flags  = '0;
            expect_q.delete();
            due_q.delete();
        end else begin
            // Outputs seen here were loaded on the previous edge
            if (due_q.size() > 0 && due_q[0] < cycle) begin
                $display("Missing pulse: a WRITEB expected abc_valid_out in cycle %0d (time %0t)",
                         due_q[0] - 1, $time);
                error_count++;
                exp_read = expect_q.pop_front();
                due      = due_q.pop_front();
            end
            if (abc_valid_out) begin
                seen_pulse = 1'b1;
                if (expect_q.size() == 0) begin
                    $display("Unexpected pulse: abc_valid_out high at time %0t with no WRITEB",
                             $time);
                    error_count++;
                end else begin
                    exp_read = expect_q.pop_front();
                    due      = due_q.pop_front();
                    pulse_count++;
                    if (due != cycle) begin
                        $display("Pulse at time %0t came %0d cycles off its WRITEB timing",
                                 $time, cycle - due);
                        error_count++;
                    end
                    compare_value("abc_out", exp_read[LINE_WIDTH-1:0], abc_out);
                    compare_value("use_new_c_out", LINE_WIDTH'(exp_read[LINE_WIDTH]),
                                  LINE_WIDTH'(use_new_c_out));
                    compare_value("fma_output_can_be_valid_out",
                                  LINE_WIDTH'(exp_read[LINE_WIDTH+1]),
                                  LINE_WIDTH'(fma_output_can_be_valid_out));
                    held_flags = exp_read[LINE_WIDTH+1:LINE_WIDTH];
                end
            end else begin
                // Flags keep the value of the last pulse, which is zero after reset
                compare_value("use_new_c_out", LINE_WIDTH'(held_flags[0]),
                              LINE_WIDTH'(use_new_c_out));
                compare_value("fma_output_can_be_valid_out", LINE_WIDTH'(held_flags[1]),
                              LINE_WIDTH'(fma_output_can_be_valid_out));
                if (!seen_pulse) begin
                    compare_value("abc_valid_out", '0, LINE_WIDTH'(abc_valid_out));
                    compare_value("abc_out", '0, abc_out);
                end
            end

            if (instr_valid_in) begin
                case (op)
                    OP_SMA:   ref_addr = imm[ADDR_WIDTH-1:0];
                    OP_LOADI: begin
                        if (idx < WORDS) begin  // Word 0 is the top word of the line
                            ref_staging[(WORDS - 1 - idx) * WORD_WIDTH +: WORD_WIDTH] = imm;
                        end
                    end
                    OP_SENDL: begin
                        if (int'(ref_addr) < LINE_DEPTH) ref_mem[ref_addr] = ref_staging;
                    end
                    OP_LOADB: begin
                        ref_addr = imm[ADDR_WIDTH-1:0];  // LOADB also moves the address
                        if (int'(ref_addr) < LINE_DEPTH) ref_mem[ref_addr] = ref_captured;
                    end
                    OP_WRITEB: begin
                        ref_addr = imm[ADDR_WIDTH-1:0];
                        expect_q.push_back(expected_read(ref_addr, ra, rb));
                        due_q.push_back(cycle + 3);  // Loaded 2 edges later, seen on the third
                    end
                    default: ;  // NOP and core opcodes
                endcase
            end
            // A line captured on this edge is only usable by a later LOADB
            if (write_buffer_valid_in) ref_captured = write_buffer_read_in;
        end
        pending = expect_q.size();
    end

endmodule

// ==== testbench/tb_memory_unit.sv ====
`timescale 1ns/1ps

module tb_memory_unit
    import mem_pkg::*;
();

    localparam int FMA_COUNT      = 2;    // Same as the DUT defaults
    localparam int LINE_DEPTH     = 375;
    localparam int WORDS          = WORDS_PER_FMA * FMA_COUNT;
    localparam int LINE_WIDTH     = WORDS * WORD_WIDTH;
    localparam int CLK_PERIOD     = 8;
    localparam int RANDOM_COUNT   = 200;
    localparam int TIMEOUT_CYCLES = 400 + 8 * RANDOM_COUNT;  // Directed part plus random steps
    localparam logic [15:0] POOL_BASE = 16'd100;  // Random traffic stays on lines 100 to 107

    logic                   clk_in;
    logic                   rst_in;
    logic [INSTR_WIDTH-1:0] instr_in;
    logic                   instr_valid_in;
    logic [LINE_WIDTH-1:0]  write_buffer_read_in;
    logic                   write_buffer_valid_in;
    logic [LINE_WIDTH-1:0]  abc_out;
    logic                   abc_valid_out;
    logic                   use_new_c_out;
    logic                   fma_output_can_be_valid_out;

    integer      seed;
    int          cycles;
    int          errors;
    int          pulses;
    int          pending;
    int          test_num;
    int          errors_before;
    logic [31:0] r_op;
    logic [31:0] r_fld;
    logic [15:0] imm_value;

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    memory_unit dut (
        .clk_in (clk_in), .rst_in (rst_in),
        .instr_in (instr_in), .instr_valid_in (instr_valid_in),
        .write_buffer_read_in (write_buffer_read_in),
        .write_buffer_valid_in (write_buffer_valid_in),
        .abc_out (abc_out), .abc_valid_out (abc_valid_out),
        .use_new_c_out (use_new_c_out),
        .fma_output_can_be_valid_out (fma_output_can_be_valid_out)
    );

    memory_checker #(.FMA_COUNT (FMA_COUNT), .LINE_DEPTH (LINE_DEPTH)) chk (
        .clk_in (clk_in), .rst_in (rst_in),
        .instr_in (instr_in), .instr_valid_in (instr_valid_in),
        .write_buffer_read_in (write_buffer_read_in),
        .write_buffer_valid_in (write_buffer_valid_in),
        .abc_out (abc_out), .abc_valid_out (abc_valid_out),
        .use_new_c_out (use_new_c_out),
        .fma_output_can_be_valid_out (fma_output_can_be_valid_out),
        .error_count (errors), .pulse_count (pulses), .pending (pending)
    );

    // Hard stop in case a handshake never completes
    always @(posedge clk_in) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [INSTR_WIDTH-1:0] encode(input logic [3:0] op, input logic [3:0] ra,
                                                      input logic [15:0] imm, input logic [3:0] rb);
        return {op, ra, imm, rb, 4'h0};  // reg_c is left at zero
    endfunction

    function automatic logic [LINE_WIDTH-1:0] random_line();
        logic [LINE_WIDTH-1:0] line;
        logic [31:0]           r;
        for (int w = 0; w < WORDS; w++) begin
            r = $random(seed);
            line[w * WORD_WIDTH +: WORD_WIDTH] = r[15:0];
        end
        return line;
    endfunction

    task automatic issue(input logic [INSTR_WIDTH-1:0] ins);
        @(posedge clk_in);
        instr_in       <= ins;
        instr_valid_in <= 1'b1;  // Stays high until the next drive
    endtask

    task automatic capture_line(input logic [LINE_WIDTH-1:0] line);
        @(posedge clk_in);
        instr_valid_in        <= 1'b0;
        write_buffer_read_in  <= line;
        write_buffer_valid_in <= 1'b1;
        @(posedge clk_in);
        write_buffer_valid_in <= 1'b0;
    endtask

    // SMA, one LOADI per word with random data, then SENDL
    task automatic write_words(input logic [15:0] addr);
        logic [31:0] r;
        issue(encode(OP_SMA, 4'h0, addr, 4'h0));
        for (int i = 0; i < WORDS; i++) begin
            r = $random(seed);
            issue(encode(OP_LOADI, 4'(i), r[15:0], 4'h0));
        end
        issue(encode(OP_SENDL, 4'h0, 16'h0, 4'h0));
    endtask

    // Stops driving and waits until every WRITEB has had its pulse checked
    task automatic finish_test(input string name);
        @(posedge clk_in);
        instr_valid_in        <= 1'b0;
        write_buffer_valid_in <= 1'b0;
        repeat (2) @(negedge clk_in);
        while (pending != 0) @(negedge clk_in);
        test_num++;
        $display("Test %0d %s: %0d errors", test_num, name, errors - errors_before);
        errors_before = errors;
    endtask

    initial begin
        seed                  = 81;
        clk_in                = 1'b0;
        rst_in                <= 1'b1;
        instr_in              <= '0;
        instr_valid_in        <= 1'b0;
        write_buffer_read_in  <= '0;
        write_buffer_valid_in <= 1'b0;
        repeat (3) @(posedge clk_in);
        rst_in <= 1'b0;

        repeat (6) @(posedge clk_in);  // Checker requires all outputs at zero here
        finish_test("idle after reset");

        issue(encode(OP_SMA, 4'h0, 16'd12, 4'h0));
        for (int i = 0; i < WORDS; i++) begin
            issue(encode(OP_LOADI, 4'(i), 16'h1100 + 16'(i) * 16'h1111, 4'h0));
        end
        issue(encode(OP_SENDL, 4'h0, 16'h0, 4'h0));
        issue(encode(OP_WRITEB, 4'h1, 16'd12, 4'h1));
        finish_test("LOADI, SENDL and WRITEB");

        capture_line(random_line());
        issue(encode(OP_LOADB, 4'h0, 16'd40, 4'h0));
        issue(encode(OP_WRITEB, 4'h0, 16'd40, 4'h1));
        finish_test("write buffer through LOADB");

        // Field values 0, 1 and 2 for both flags
        for (int a = 0; a < 3; a++) begin
            for (int b = 0; b < 3; b++) begin
                issue(encode(OP_WRITEB, 4'(a), 16'd12, 4'(b)));
            end
        end
        finish_test("WRITEB flag fields");

        for (int n = 0; n < 4; n++) write_words(16'd30 + 16'(n));
        for (int n = 0; n < 6; n++) issue(encode(OP_WRITEB, 4'h1, 16'd30 + 16'(n % 4), 4'h0));
        finish_test("back-to-back WRITEB");

        for (int w = 0; w < 8; w++) write_words(POOL_BASE + 16'(w));
        repeat (RANDOM_COUNT) begin
            r_op  = $random(seed);
            r_fld = $random(seed);
            // Address opcodes stay inside the pool so every read hits a written line
            if (r_op[3:0] == OP_SMA || r_op[3:0] == OP_LOADB || r_op[3:0] == OP_WRITEB) begin
                imm_value = POOL_BASE + 16'(r_fld[18:16]);
            end else begin
                imm_value = r_fld[31:16];
            end
            @(posedge clk_in);
            instr_in              <= encode(r_op[3:0], r_fld[3:0], imm_value, r_fld[7:4]);
            instr_valid_in        <= r_op[6:4] != 3'd0;  // About one idle slot in eight
            write_buffer_read_in  <= random_line();
            write_buffer_valid_in <= r_op[8];
        end
        finish_test("random instructions");

        $display("Done: %0d tests, %0d pulses compared, %0d errors", test_num, pulses, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
